/* sim.f */
design/traceBatchPkg.sv
design/traceStageIf.sv
design/traceCapture.sv
design/traceCompactStage.sv
design/traceRecordOut.sv
design/traceBatch.sv
verif/traceClock.sv
verif/traceBatchTb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the trace batcher testbench with Verilator, runs it and checks the log.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module traceBatchTb -f sim.f --Mdir obj_dir -o simv

./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification passed" sim.log; then
    echo "Simulation run OK"
    exit 0
else
    echo "Simulation run FAILED"
    exit 1
fi

/* verif/traceBatchTb.sv */
`timescale 1ns/10ps

module traceBatchTb;

    localparam logic [31:0] Seed = 32'h23180746;
    localparam int Timeout = 200;
    localparam int LatencyEdges = 6;
    localparam int Depth = 7;
    localparam int Widths [traceBatchPkg::NumTraces] = '{
        traceBatchPkg::TraceWidth0, traceBatchPkg::TraceWidth1, traceBatchPkg::TraceWidth2,
        traceBatchPkg::TraceWidth3, traceBatchPkg::TraceWidth4
    };
    localparam int AllOffsets [traceBatchPkg::NumTraces] = '{0, 2, 8, 13, 24};

    // Each channel gets a 96-bit lane holding data masked to the channel width.
    typedef logic [traceBatchPkg::NumTraces-1:0][95:0] batchDataT;

    logic clk;
    logic rst;
    logic tk0_valid, tk0_ready, tk0_enable;
    logic tk1_valid, tk1_ready, tk1_enable;
    logic tk2_valid, tk2_ready, tk2_enable;
    logic tk3_valid, tk3_ready, tk3_enable;
    logic tk4_valid, tk4_ready, tk4_enable;
    traceBatchPkg::trace0DataT tk0_data;
    traceBatchPkg::trace1DataT tk1_data;
    traceBatchPkg::trace2DataT tk2_data;
    traceBatchPkg::trace3DataT tk3_data;
    traceBatchPkg::trace4DataT tk4_data;
    logic ovalid;
    logic oready;
    traceBatchPkg::outDataT odata;
    traceBatchPkg::lenT olen;

    traceBatchPkg::outDataT expData [$];
    traceBatchPkg::lenT expLen [$];
    traceBatchPkg::seqT modelSeq;
    traceBatchPkg::outDataT lastData;
    traceBatchPkg::lenT lastLen;

    traceClock clockGen (.clk(clk), .rst(rst));

    traceBatch traceBatch_i (.*);

    // ####################################################################
    // Failure reporting and compare tasks
    // ####################################################################

    task automatic stopFailed();
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic abortWith(input string msg);
        $display("%s", msg);
        stopFailed();
    endtask

    task automatic checkData(input string name, input traceBatchPkg::outDataT got,
                             input traceBatchPkg::outDataT exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s = %h, expected %h", $time, name, got, exp);
            stopFailed();
        end
    endtask

    task automatic checkLen(input string name, input traceBatchPkg::lenT got,
                            input traceBatchPkg::lenT exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s = %0d, expected %0d", $time, name, got, exp);
            stopFailed();
        end
    endtask

    // ####################################################################
    // Reference model
    // ####################################################################

    // Slots go in channel order from byte 0, then the marker and the sequence number.
    function automatic void modelRecord(input traceBatchPkg::enableT inc, input batchDataT d,
                                        input traceBatchPkg::seqT seq,
                                        output traceBatchPkg::outDataT rec,
                                        output traceBatchPkg::lenT len);
        int pos;
        pos = 0;
        rec = '0;
        for (int ch = 0; ch < traceBatchPkg::NumTraces; ch++) begin
            if (inc[ch]) begin
                rec[pos*8 +: 8] = 8'(ch);
                for (int b = 1; b < traceBatchPkg::SlotBytes[ch]; b++) begin
                    rec[(pos+b)*8 +: 8] = d[ch][(b-1)*8 +: 8];
                end
                pos += traceBatchPkg::SlotBytes[ch];
            end
        end
        rec[pos*8 +: 8] = traceBatchPkg::EndMarker;
        rec[(pos+1)*8 +: 64] = seq;
        len = traceBatchPkg::lenT'(pos + traceBatchPkg::TrailerBytes);
    endfunction

    task automatic expectBatch(input traceBatchPkg::enableT inc, input batchDataT d);
        traceBatchPkg::outDataT rec;
        traceBatchPkg::lenT len;
        modelRecord(inc, d, modelSeq, rec, len);
        modelSeq = modelSeq + 64'd1;
        expData.push_back(rec);
        expLen.push_back(len);
    endtask

    // ####################################################################
    // Stimulus helpers
    // ####################################################################

    task automatic randomData(output batchDataT d);
        for (int ch = 0; ch < traceBatchPkg::NumTraces; ch++) begin
            d[ch] = {$urandom, $urandom, $urandom};
            d[ch] = d[ch] & ((96'd1 << Widths[ch]) - 96'd1);
        end
    endtask

    task automatic driveInputs(input traceBatchPkg::enableT v, input traceBatchPkg::enableT e,
                               input batchDataT d);
        tk0_valid  <= v[0];
        tk0_enable <= e[0];
        tk0_data   <= traceBatchPkg::trace0DataT'(d[0]);
        tk1_valid  <= v[1];
        tk1_enable <= e[1];
        tk1_data   <= traceBatchPkg::trace1DataT'(d[1]);
        tk2_valid  <= v[2];
        tk2_enable <= e[2];
        tk2_data   <= traceBatchPkg::trace2DataT'(d[2]);
        tk3_valid  <= v[3];
        tk3_enable <= e[3];
        tk3_data   <= traceBatchPkg::trace3DataT'(d[3]);
        tk4_valid  <= v[4];
        tk4_enable <= e[4];
        tk4_data   <= traceBatchPkg::trace4DataT'(d[4]);
    endtask

    task automatic idleInputs();
        @(posedge clk);
        driveInputs('0, '0, '0);
    endtask

    // The batch is taken on the edge after the falling edge that sees ready high.
    task automatic awaitAccept(input traceBatchPkg::enableT v, input traceBatchPkg::enableT e,
                               input batchDataT d);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!tk0_ready) begin
            waited++;
            if (waited > Timeout) abortWith("Timed out waiting for tk0_ready.");
            @(negedge clk);
        end
        if ({tk4_ready, tk3_ready, tk2_ready, tk1_ready} !== 4'b1111)
            abortWith("The five tkN_ready outputs do not agree.");
        if (|(v & e)) expectBatch(v & e, d);
    endtask

    task automatic issueBatch(input traceBatchPkg::enableT v, input traceBatchPkg::enableT e,
                              input batchDataT d);
        @(posedge clk);
        driveInputs(v, e, d);
        awaitAccept(v, e, d);
    endtask

    task automatic waitDrained();
        int waited;
        waited = 0;
        while (expData.size() != 0) begin
            waited++;
            if (waited > Timeout) abortWith("Timed out waiting for output records.");
            @(negedge clk);
        end
    endtask

    task automatic waitReset();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!rst) begin
            waited++;
            if (waited > Timeout) abortWith("Reset was never released.");
            @(negedge clk);
        end
        if (ovalid !== 1'b0) abortWith("ovalid is not low after reset.");
        if (tk0_ready !== 1'b1) abortWith("tk0_ready is not high after reset.");
    endtask

    // ####################################################################
    // Directed tests
    // ####################################################################

    task automatic singleChannels();
        batchDataT d;
        traceBatchPkg::enableT sel;
        for (int ch = 0; ch < traceBatchPkg::NumTraces; ch++) begin
            randomData(d);
            sel = traceBatchPkg::enableT'(1 << ch);
            issueBatch(sel, sel, d);
            idleInputs();
            waitDrained();
            checkLen("olen", lastLen, traceBatchPkg::lenT'(traceBatchPkg::SlotBytes[ch] + 9));
        end
    endtask

    task automatic allChannels();
        batchDataT d;
        traceBatchPkg::outDataT idMask;
        traceBatchPkg::outDataT ids;
        idMask = '0;
        ids = '0;
        randomData(d);
        issueBatch('1, '1, d);
        idleInputs();
        waitDrained();
        for (int ch = 0; ch < traceBatchPkg::NumTraces; ch++) begin
            idMask[AllOffsets[ch]*8 +: 8] = 8'hff;
            ids[AllOffsets[ch]*8 +: 8] = 8'(ch);
        end
        checkData("odata slot identifiers", lastData & idMask, ids);
        checkLen("olen", lastLen, 6'd46);
    endtask

    task automatic randomSubsets();
        batchDataT d;
        traceBatchPkg::enableT v;
        traceBatchPkg::enableT e;
        for (int n = 0; n < 24; n++) begin
            randomData(d);
            v = traceBatchPkg::enableT'($urandom);
            e = traceBatchPkg::enableT'($urandom);
            issueBatch(v, e, d);
        end
        idleInputs();
        waitDrained();
    endtask

    task automatic excludedInputs();
        batchDataT d;
        randomData(d);
        @(posedge clk);
        driveInputs('1, '0, d);
        idleInputs();
        for (int n = 0; n < LatencyEdges + 4; n++) begin
            @(negedge clk);
            if (ovalid) abortWith("An output appeared for a cycle with no enabled channel.");
        end
        // Channel 2 is enabled but not valid, so only channel 0 belongs to the batch.
        issueBatch(5'b00001, 5'b00101, d);
        idleInputs();
        waitDrained();
        checkLen("olen", lastLen, traceBatchPkg::lenT'(traceBatchPkg::SlotBytes[0] + 9));
    endtask

    task automatic measureLatency();
        batchDataT d;
        int edges;
        randomData(d);
        issueBatch(5'b01010, 5'b11110, d);
        idleInputs();
        edges = 0;
        @(negedge clk);
        while (!ovalid) begin
            if (edges > Timeout) abortWith("Timed out waiting for ovalid.");
            @(posedge clk);
            edges++;
            @(negedge clk);
        end
        if (edges != LatencyEdges) begin
            $display("ERROR at %0t: ovalid latency = %0d, expected %0d", $time, edges,
                     LatencyEdges);
            stopFailed();
        end
        waitDrained();
    endtask

    task automatic backPressure();
        batchDataT d;
        traceBatchPkg::enableT e;
        int accepted;
        accepted = 0;
        randomData(d);
        e = traceBatchPkg::enableT'($urandom) | 5'b00001;
        @(posedge clk);
        oready <= 1'b0;
        driveInputs('1, e, d);
        @(negedge clk);
        while (tk0_ready) begin
            expectBatch(e, d);
            accepted++;
            if (accepted > Depth + 2) abortWith("tk0_ready did not fall under back-pressure.");
            randomData(d);
            e = traceBatchPkg::enableT'($urandom) | 5'b00001;
            @(posedge clk);
            driveInputs('1, e, d);
            @(negedge clk);
        end
        if ({tk4_ready, tk3_ready, tk2_ready, tk1_ready} !== 4'b0000)
            abortWith("The five tkN_ready outputs do not agree.");
        if (accepted != Depth) begin
            $display("ERROR at %0t: accepted batches = %0d, expected %0d", $time, accepted,
                     Depth);
            stopFailed();
        end
        @(posedge clk);
        oready <= 1'b1;
        awaitAccept('1, e, d);
        idleInputs();
        waitDrained();
    endtask

    // ####################################################################
    // Output monitor and main sequence
    // ####################################################################

    initial begin : outputMonitor
        traceBatchPkg::outDataT xd;
        traceBatchPkg::lenT xl;
        forever begin
            @(negedge clk);
            if (rst && ovalid && oready) begin
                if (expData.size() == 0) begin
                    abortWith("An output record arrived with no batch pending.");
                end else begin
                    xd = expData.pop_front();
                    xl = expLen.pop_front();
                    checkData("odata", odata, xd);
                    checkLen("olen", olen, xl);
                    lastData = odata;
                    lastLen = olen;
                end
            end
        end
    end

    initial begin
        void'($urandom(Seed));
        driveInputs('0, '0, '0);
        oready = 1'b1;
        modelSeq = '0;
        waitReset();
        singleChannels();
        allChannels();
        randomSubsets();
        excludedInputs();
        measureLatency();
        backPressure();
        if (expData.size() == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            abortWith("Some batches never produced an output record.");
        end
    end

endmodule

/* verif/traceClock.sv */
`timescale 1ns/10ps

// Free-running testbench clock with an active-low reset held for a few cycles.
module traceClock #(
    parameter int HalfPeriod  = 20,
    parameter int ResetCycles = 3
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #HalfPeriod clk = ~clk;
    end

    initial begin
        rst = 1'b0;
        repeat (ResetCycles) @(posedge clk);
        rst <= 1'b1;
    end

endmodule

/* design/traceBatch.sv */
`timescale 1ns/10ps

module traceBatch (
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       tk0_valid,
    output logic                       tk0_ready,
    input  logic                       tk0_enable,
    input  traceBatchPkg::trace0DataT  tk0_data,

    input  logic                       tk1_valid,
    output logic                       tk1_ready,
    input  logic                       tk1_enable,
    input  traceBatchPkg::trace1DataT  tk1_data,

    input  logic                       tk2_valid,
    output logic                       tk2_ready,
    input  logic                       tk2_enable,
    input  traceBatchPkg::trace2DataT  tk2_data,

    input  logic                       tk3_valid,
    output logic                       tk3_ready,
    input  logic                       tk3_enable,
    input  traceBatchPkg::trace3DataT  tk3_data,

    input  logic                       tk4_valid,
    output logic                       tk4_ready,
    input  logic                       tk4_enable,
    input  traceBatchPkg::trace4DataT  tk4_data,

    output logic                       ovalid,
    output traceBatchPkg::outDataT     odata,
    output traceBatchPkg::lenT         olen,
    input  logic                       oready
);

    traceBatchPkg::enableT tkValid;
    traceBatchPkg::enableT tkEnable;
    logic                  canAccept;

    assign tkValid  = {tk4_valid, tk3_valid, tk2_valid, tk1_valid, tk0_valid};
    assign tkEnable = {tk4_enable, tk3_enable, tk2_enable, tk1_enable, tk0_enable};

    // All channels share one capture register, so they see the same ready.
    assign tk0_ready = canAccept;
    assign tk1_ready = canAccept;
    assign tk2_ready = canAccept;
    assign tk3_ready = canAccept;
    assign tk4_ready = canAccept;

    // ######################################################################
    // Pipeline
    // ######################################################################

    traceStageIf link [traceBatchPkg::NumTraces+1] ();

    traceCapture capture (
        .clk       (clk),
        .rst       (rst),
        .tkValid   (tkValid),
        .tkEnable  (tkEnable),
        .tk0Data   (tk0_data),
        .tk1Data   (tk1_data),
        .tk2Data   (tk2_data),
        .tk3Data   (tk3_data),
        .tk4Data   (tk4_data),
        .canAccept (canAccept),
        .out       (link[0])
    );

    // One stage per channel, lowest channel first.
    for (genvar i = 0; i < traceBatchPkg::NumTraces; i++) begin : gStage
        traceCompactStage #(
            .Channel (i)
        ) stage (
            .clk  (clk),
            .rst  (rst),
            .up   (link[i]),
            .down (link[i+1])
        );
    end

    traceRecordOut recordOut (
        .clk    (clk),
        .rst    (rst),
        .in     (link[traceBatchPkg::NumTraces]),
        .ovalid (ovalid),
        .odata  (odata),
        .olen   (olen),
        .oready (oready)
    );

endmodule

/* design/traceRecordOut.sv */
`timescale 1ns/10ps

module traceRecordOut (
    input  logic                    clk,
    input  logic                    rst,
    traceStageIf.snk                in,
    output logic                    ovalid,
    output traceBatchPkg::outDataT  odata,
    output traceBatchPkg::lenT      olen,
    input  logic                    oready
);

    traceBatchPkg::outDataT word;
    traceBatchPkg::seqT     seq;
    logic                   full;

    // Bytes above len are already zero after compaction, so the trailer
    // can be written straight into them.
    always_comb begin
        word = traceBatchPkg::outDataT'(in.record);
        word[{in.len, 3'b000} +: 8] = traceBatchPkg::EndMarker;
        word[{in.len, 3'b000} + 8 +: 64] = seq;
    end

    assign in.ready = !full || oready;

    // ######################################################################
    // Output register and sequence counter
    // ######################################################################

    always_ff @(posedge clk) begin
        if (!rst) begin
            full <= 1'b0;
        end else if (in.ready) begin
            full <= in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            seq <= '0;
        end else if (in.valid && in.ready) begin
            seq <= seq + 64'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (in.valid && in.ready) begin
            odata <= word;
            olen  <= in.len + traceBatchPkg::lenT'(traceBatchPkg::TrailerBytes);
        end
    end

    assign ovalid = full;

endmodule

/* design/traceCompactStage.sv */
`timescale 1ns/10ps

module traceCompactStage #(
    parameter int Channel = 0
) (
    input  logic     clk,
    input  logic     rst,
    traceStageIf.snk up,
    traceStageIf.src down
);

    traceBatchPkg::recordT lowMask;
    traceBatchPkg::recordT removed;
    logic                  keep;

    logic                  full;
    traceBatchPkg::recordT recordQ;
    traceBatchPkg::lenT    lenQ;
    traceBatchPkg::enableT enablesQ;

    assign keep = up.enables[Channel];

    // ######################################################################
    // Slot removal
    // ######################################################################

    // Lower channels are already compacted, so this slot begins at byte len.
    // Bytes below len stay in place and everything past the slot drops down.
    always_comb begin
        lowMask = ~(traceBatchPkg::recordT'('1) << {up.len, 3'b000});
        removed = (up.record & lowMask)
                | ((up.record >> (traceBatchPkg::SlotBytes[Channel] * 8)) & ~lowMask);
    end

    // ######################################################################
    // Stage register
    // ######################################################################

    assign up.ready = !full || down.ready;

    always_ff @(posedge clk) begin
        if (!rst) begin
            full <= 1'b0;
        end else if (up.ready) begin
            full <= up.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (up.valid && up.ready) begin
            enablesQ <= up.enables;
            if (keep) begin
                recordQ <= up.record;
                lenQ    <= up.len + traceBatchPkg::lenT'(traceBatchPkg::SlotBytes[Channel]);
            end else begin
                recordQ <= removed;
                lenQ    <= up.len;
            end
        end
    end

    assign down.valid   = full;
    assign down.record  = recordQ;
    assign down.len     = lenQ;
    assign down.enables = enablesQ;

endmodule

/* design/traceCapture.sv */
`timescale 1ns/10ps

module traceCapture (
    input  logic                       clk,
    input  logic                       rst,
    input  traceBatchPkg::enableT      tkValid,
    input  traceBatchPkg::enableT      tkEnable,
    input  traceBatchPkg::trace0DataT  tk0Data,
    input  traceBatchPkg::trace1DataT  tk1Data,
    input  traceBatchPkg::trace2DataT  tk2Data,
    input  traceBatchPkg::trace3DataT  tk3Data,
    input  traceBatchPkg::trace4DataT  tk4Data,
    output logic                       canAccept,
    traceStageIf.src                   out
);

    traceBatchPkg::enableT included;
    traceBatchPkg::recordT fullRecord;

    logic                  full;
    traceBatchPkg::recordT recordQ;
    traceBatchPkg::enableT enablesQ;

    // A channel joins the batch only when it is both valid and enabled.
    assign included = tkValid & tkEnable;

    assign canAccept = !full || out.ready;

    // ######################################################################
    // Uncompacted record
    // ######################################################################

    always_comb begin
        fullRecord = '0;
        for (int i = 0; i < traceBatchPkg::NumTraces; i++) begin
            fullRecord[traceBatchPkg::SlotOffset[i]*8 +: 8] = 8'(i);
        end
        fullRecord[traceBatchPkg::SlotOffset[0]*8 + 8 +: traceBatchPkg::TraceWidth0] = tk0Data;
        fullRecord[traceBatchPkg::SlotOffset[1]*8 + 8 +: traceBatchPkg::TraceWidth1] = tk1Data;
        fullRecord[traceBatchPkg::SlotOffset[2]*8 + 8 +: traceBatchPkg::TraceWidth2] = tk2Data;
        fullRecord[traceBatchPkg::SlotOffset[3]*8 + 8 +: traceBatchPkg::TraceWidth3] = tk3Data;
        fullRecord[traceBatchPkg::SlotOffset[4]*8 + 8 +: traceBatchPkg::TraceWidth4] = tk4Data;
    end

    // ######################################################################
    // Capture register
    // ######################################################################

    // When nothing is included the register empties as soon as its content moves on.
    always_ff @(posedge clk) begin
        if (!rst) begin
            full <= 1'b0;
        end else if (canAccept) begin
            full <= |included;
        end
    end

    always_ff @(posedge clk) begin
        if (canAccept && |included) begin
            recordQ  <= fullRecord;
            enablesQ <= included;
        end
    end

    assign out.valid   = full;
    assign out.record  = recordQ;
    assign out.enables = enablesQ;

    // Nothing is compacted yet, so the stages start counting from byte 0.
    assign out.len = '0;

endmodule

/* design/traceStageIf.sv */
`timescale 1ns/10ps

// One record moving between two pipeline registers.
interface traceStageIf;

    logic valid;
    logic ready;
    traceBatchPkg::recordT record;
    traceBatchPkg::lenT len;
    traceBatchPkg::enableT enables;

    modport src (
        output valid,
        input  ready,
        output record,
        output len,
        output enables
    );

    modport snk (
        input  valid,
        output ready,
        input  record,
        input  len,
        input  enables
    );

endinterface

/* design/traceBatchPkg.sv */
package traceBatchPkg;

    // ######################################################################
    // Channel set
    // ######################################################################

    localparam int NumTraces = 5;

    localparam int TraceWidth0 = 6;
    localparam int TraceWidth1 = 34;
    localparam int TraceWidth2 = 26;
    localparam int TraceWidth3 = 74;
    localparam int TraceWidth4 = 93;

    // ######################################################################
    // Record layout
    // ######################################################################

    // Each slot holds an identifier byte and the channel data rounded up to bytes.
    localparam int SlotBytes [NumTraces] = '{2, 6, 5, 11, 13};

    // Byte offset of each slot in the uncompacted record.
    localparam int SlotOffset [NumTraces] = '{
        0,
        SlotBytes[0],
        SlotBytes[0] + SlotBytes[1],
        SlotBytes[0] + SlotBytes[1] + SlotBytes[2],
        SlotBytes[0] + SlotBytes[1] + SlotBytes[2] + SlotBytes[3]
    };

    localparam int RecordBytes = 37;
    localparam int OutBytes = 48;

    localparam logic [7:0] EndMarker = 8'h80;

    // Marker byte plus the 8-byte sequence number.
    localparam int TrailerBytes = 9;

    // ######################################################################
    // Types
    // ######################################################################

    typedef logic [TraceWidth0-1:0] trace0DataT;
    typedef logic [TraceWidth1-1:0] trace1DataT;
    typedef logic [TraceWidth2-1:0] trace2DataT;
    typedef logic [TraceWidth3-1:0] trace3DataT;
    typedef logic [TraceWidth4-1:0] trace4DataT;

    typedef logic [NumTraces-1:0] enableT;
    typedef logic [RecordBytes*8-1:0] recordT;
    typedef logic [5:0] lenT;
    typedef logic [63:0] seqT;
    typedef logic [OutBytes*8-1:0] outDataT;

endpackage
